/* include/fpu_params.svh */
// fpu parameters
// widths, exponent bias, register map and multiplier step count
// for the byte-bus single-precision coprocessor

`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// datapath widths
`define FPU_WORD_W    32
`define FPU_BYTE_W    8   // host data bus
`define FPU_ADDR_W    4
`define FPU_EXP_W     8
`define FPU_MAN_W     23  // stored fraction, hidden bit not counted

`define FPU_EXP_BIAS  127
`define FPU_MUL_STEPS 24  // one add/shift pair per multiplier bit

// register map base addresses
`define FPU_REG_A0    4'h0  // operand a, bytes 0..3, lsb first
`define FPU_REG_B0    4'h4  // operand b, bytes 4..7
`define FPU_REG_OP    4'h8  // opcode, low nibble
`define FPU_REG_R0    4'h9  // result, bytes 9..c (read only)

`endif

/* rtl/fpu_pkg.sv */
// fpu package
// opcode and sequencer state enums, float word layout,
// operand pair and multiplier command structs

`include "fpu_params.svh"

package fpu_pkg;

  // opcode as written to the op register, low nibble
  typedef enum logic [3:0] {
    op_add = 4'd0,
    op_sub = 4'd1,
    op_mul = 4'd2
  } fpu_op_e;

  // sequencer states
  typedef enum logic [2:0] {
    idle_st,
    addsub_st,     // single cycle add/sub
    mul_load_st,
    mul_add_st,
    mul_shift_st,
    mul_norm_st,   // product settled, capture on exit
    done_st        // cmd_end, wait for end_ack
  } fpu_state_e;

  // ieee-754 single, field view
  typedef struct packed {
    logic                  sign;
    logic [`FPU_EXP_W-1:0] exp;
    logic [`FPU_MAN_W-1:0] frac;
  } fpu_word_t;

  typedef struct packed {
    fpu_word_t a;
    fpu_word_t b;
  } fpu_operands_t;

  // one-hot commands to the multiplier datapath
  typedef struct packed {
    logic load;   // init product and multiplicand
    logic add;    // conditional add, count step
    logic shift;  // product >> 1
  } mul_cmd_t;

endpackage

/* rtl/fpu_reg_bank.sv */
// fpu register bank
// byte-wide host writes to operands and opcode, result register
// loaded from the selected arithmetic unit, combinational readback
// start pulses one cycle after an opcode write seen while idle

`include "fpu_params.svh"

module fpu_reg_bank import fpu_pkg::*; (
  input  logic                   clk,
  input  logic                   arst,
  input  logic                   cs,
  input  logic                   rd,
  input  logic                   wr,
  input  logic [`FPU_ADDR_W-1:0] addr,
  input  logic [`FPU_BYTE_W-1:0] databus_in,
  input  logic                   idle,
  input  logic                   capture,
  input  logic                   capture_sel,  // 1 selects multiplier
  input  fpu_word_t              addsub_res,
  input  fpu_word_t              mul_res,
  output logic [`FPU_BYTE_W-1:0] databus_out,
  output fpu_operands_t          operands,
  output fpu_op_e                op,
  output logic                   start
);

  localparam logic [`FPU_ADDR_W-1:0] word_bytes =
    `FPU_ADDR_W'(`FPU_WORD_W / `FPU_BYTE_W);
  localparam int sel_w = $clog2(`FPU_WORD_W / `FPU_BYTE_W);
  localparam int op_w  = $bits(fpu_op_e);

  logic                   wr_en;
  logic                   rd_en;
  logic [`FPU_ADDR_W-1:0] off_a;  // offsets from each base
  logic [`FPU_ADDR_W-1:0] off_b;
  logic [`FPU_ADDR_W-1:0] off_r;
  fpu_word_t              result;

  assign wr_en = !cs && !wr;  // strobes are plain active-low levels
  assign rd_en = !cs && !rd;
  assign off_a = addr - `FPU_REG_A0;
  assign off_b = addr - `FPU_REG_B0;
  assign off_r = addr - `FPU_REG_R0;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      operands <= '0;
      op       <= op_add;
      start    <= 1'b0;
      result   <= '0;
    end else begin
      start <= 1'b0;
      if (wr_en) begin
        if (off_a < word_bytes) begin
          operands.a[off_a[sel_w-1:0]*`FPU_BYTE_W +: `FPU_BYTE_W] <= databus_in;
        end else if (off_b < word_bytes) begin
          operands.b[off_b[sel_w-1:0]*`FPU_BYTE_W +: `FPU_BYTE_W] <= databus_in;
        end else if (addr == `FPU_REG_OP) begin
          op    <= fpu_op_e'(databus_in[op_w-1:0]);
          start <= idle;  // ignored while an op is running
        end
      end
      if (capture) result <= capture_sel ? mul_res : addsub_res;
    end
  end

  // readback, zero when unselected or unmapped
  always_comb begin
    databus_out = '0;
    if (rd_en) begin
      if (off_a < word_bytes)
        databus_out = operands.a[off_a[sel_w-1:0]*`FPU_BYTE_W +: `FPU_BYTE_W];
      else if (off_b < word_bytes)
        databus_out = operands.b[off_b[sel_w-1:0]*`FPU_BYTE_W +: `FPU_BYTE_W];
      else if (addr == `FPU_REG_OP)
        databus_out = {{(`FPU_BYTE_W-op_w){1'b0}}, op};
      else if (off_r < word_bytes)
        databus_out = result[off_r[sel_w-1:0]*`FPU_BYTE_W +: `FPU_BYTE_W];
    end
  end

endmodule

/* rtl/fpu_add_sub.sv */
// fpu adder/subtractor
// single-cycle combinational add or subtract of two singles
// aligns exponents, sums in two's complement, normalises the result
// mantissas are truncated, no rounding or special values

`include "fpu_params.svh"

module fpu_add_sub import fpu_pkg::*; (
  input  fpu_operands_t operands,
  input  logic          subtract,
  output fpu_word_t     result
);

  localparam int man_w = `FPU_MAN_W + 1;  // with hidden bit
  localparam int sum_w = man_w + 2;       // carry plus sign
  localparam int ew    = `FPU_EXP_W + 2;  // signed, room to unbias
  localparam int sh_w  = $clog2(man_w);
  localparam logic signed [ew-1:0] exp_bias = ew'(`FPU_EXP_BIAS);

  logic        [man_w-1:0] a_man;
  logic        [man_w-1:0] b_man;
  logic        [man_w-1:0] a_al;     // after alignment
  logic        [man_w-1:0] b_al;
  logic signed [ew-1:0]    a_exp;    // unbiased
  logic signed [ew-1:0]    b_exp;
  logic        [ew-1:0]    exp_diff;
  logic signed [ew-1:0]    res_exp;
  logic signed [ew-1:0]    exp_out;
  logic signed [sum_w-1:0] a_s;
  logic signed [sum_w-1:0] b_s;
  logic signed [sum_w-1:0] sum;
  logic        [sum_w-1:0] mag;
  logic                    res_sign;
  logic        [sh_w-1:0]  shamt;

  always_comb begin
    a_man = {operands.a.exp != '0, operands.a.frac};  // exp 0 treated as zero
    b_man = {operands.b.exp != '0, operands.b.frac};
    a_exp = signed'({2'b00, operands.a.exp}) - exp_bias;
    b_exp = signed'({2'b00, operands.b.exp}) - exp_bias;

    // shift the smaller operand right, keep the larger exponent
    if (a_exp >= b_exp) begin
      exp_diff = a_exp - b_exp;
      a_al     = a_man;
      b_al     = b_man >> exp_diff;
      res_exp  = a_exp;
    end else begin
      exp_diff = b_exp - a_exp;
      a_al     = a_man >> exp_diff;
      b_al     = b_man;
      res_exp  = b_exp;
    end

    a_s = {2'b00, a_al};
    b_s = {2'b00, b_al};
    if (operands.a.sign) a_s = -a_s;  // two's complement for negatives
    if (operands.b.sign) b_s = -b_s;
    sum = subtract ? a_s - b_s : a_s + b_s;

    res_sign = sum[sum_w-1];
    mag      = res_sign ? -sum : sum;  // magnitude, top bit always clear
    shamt    = '0;
    exp_out  = '0;
    result   = '0;  // cancellation gives +0
    if (sum != '0) begin
      if (mag[man_w]) begin  // carry out of hidden bit
        mag     = mag >> 1;
        res_exp = res_exp + ew'(1);
      end
      // leading one search, highest set bit wins
      for (int i = 0; i < man_w; i++) begin
        if (mag[i]) shamt = sh_w'(man_w - 1 - i);
      end
      mag     = mag << shamt;
      res_exp = res_exp - ew'(shamt);
      exp_out = res_exp + exp_bias;  // rebias
      result.sign = res_sign;
      result.exp  = exp_out[`FPU_EXP_W-1:0];
      result.frac = mag[man_w-2:0];
    end
  end

endmodule

/* rtl/fpu_mul_unit.sv */
// fpu multiplier
// sequential shift-and-add mantissa multiplier, one bit per add/shift pair
// 49-bit product register holds partial product over multiplier bits
// result is normalised combinationally from the product register

`include "fpu_params.svh"

module fpu_mul_unit import fpu_pkg::*; (
  input  logic          clk,
  input  logic          arst,
  input  fpu_operands_t operands,
  input  mul_cmd_t      mul_cmd,
  output logic          mul_last,
  output fpu_word_t     result
);

  localparam int man_w  = `FPU_MAN_W + 1;      // 24 with hidden bit
  localparam int prod_w = 2 * man_w + 1;       // extra bit keeps add carry
  localparam int cnt_w  = $clog2(`FPU_MUL_STEPS + 1);
  localparam logic [`FPU_EXP_W-1:0] exp_bias = `FPU_EXP_W'(`FPU_EXP_BIAS);

  logic [prod_w-1:0]     product;   // upper: partial sum, lower: multiplier
  logic [man_w-1:0]      mcand;     // multiplicand, a mantissa
  logic [cnt_w-1:0]      step_cnt;
  logic [man_w-1:0]      a_man;
  logic [man_w-1:0]      b_man;
  logic [man_w-1:0]      top_man;
  logic [`FPU_EXP_W-1:0] exp_sum;

  assign a_man    = {operands.a.exp != '0, operands.a.frac};
  assign b_man    = {operands.b.exp != '0, operands.b.frac};
  assign mul_last = step_cnt == cnt_w'(`FPU_MUL_STEPS);

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      product  <= '0;
      mcand    <= '0;
      step_cnt <= '0;
    end else if (mul_cmd.load) begin
      mcand    <= a_man;
      product  <= {{(man_w+1){1'b0}}, b_man};
      step_cnt <= '0;
    end else if (mul_cmd.add) begin
      if (product[0])  // multiplier lsb
        product[prod_w-1:man_w] <= product[prod_w-1:man_w] + {1'b0, mcand};
      step_cnt <= step_cnt + 1'b1;  // counted here so shift_st can test it
    end else if (mul_cmd.shift) begin
      product <= product >> 1;
    end
  end

  // normalise: product of two 1.x values is 1.x or 1x.x
  always_comb begin
    exp_sum = operands.a.exp + operands.b.exp - exp_bias;
    if (product[2*man_w-1]) begin
      top_man = product[2*man_w-1:man_w];      // 1x.x, bump exponent
      exp_sum = exp_sum + 1'b1;
    end else begin
      top_man = product[2*man_w-2:man_w-1];    // shift left once
    end
    result      = '0;
    if (product[2*man_w-1:man_w-1] != '0) begin  // zero operand gives +0
      result.sign = operands.a.sign ^ operands.b.sign;
      result.exp  = exp_sum;
      result.frac = top_man[man_w-2:0];  // truncated
    end
  end

endmodule

/* rtl/fpu_sequencer.sv */
// fpu sequencer
// operation FSM: one-cycle add/sub, 24 add/shift pairs for multiply,
// then holds done until the host acknowledges with end_ack

module fpu_sequencer import fpu_pkg::*; (
  input  logic     clk,
  input  logic     arst,
  input  logic     start,
  input  fpu_op_e  op,
  input  logic     mul_last,
  input  logic     end_ack,
  output logic     idle,
  output mul_cmd_t mul_cmd,
  output logic     capture,
  output logic     capture_sel,  // 0 add/sub, 1 multiply
  output logic     busy,
  output logic     cmd_end
);

  fpu_state_e state;
  fpu_state_e state_nxt;

  always_ff @(posedge clk or posedge arst) begin
    if (arst) state <= idle_st;
    else      state <= state_nxt;
  end

  always_comb begin
    state_nxt = state;
    case (state)
      idle_st:
        if (start) begin
          case (op)
            op_add, op_sub: state_nxt = addsub_st;
            op_mul:         state_nxt = mul_load_st;
            default:        state_nxt = idle_st;  // unknown code, stay put
          endcase
        end
      addsub_st:    state_nxt = done_st;
      mul_load_st:  state_nxt = mul_add_st;
      mul_add_st:   state_nxt = mul_shift_st;
      mul_shift_st: state_nxt = mul_last ? mul_norm_st : mul_add_st;
      mul_norm_st:  state_nxt = done_st;
      done_st:      if (end_ack) state_nxt = idle_st;
      default:      state_nxt = idle_st;
    endcase
  end

  // moore decodes of the registered state
  always_comb begin
    mul_cmd       = '0;
    mul_cmd.load  = state == mul_load_st;
    mul_cmd.add   = state == mul_add_st;
    mul_cmd.shift = state == mul_shift_st;
  end

  assign idle        = state == idle_st;
  assign capture     = (state == addsub_st) || (state == mul_norm_st);  // on exit
  assign capture_sel = state == mul_norm_st;
  assign busy        = (state != idle_st) && (state != done_st);
  assign cmd_end     = state == done_st;  // irq to host

endmodule

/* rtl/fpu.sv */
// fpu top level
// byte-bus single-precision coprocessor: add, sub and multiply
// register bank on the host side, sequencer driving the arithmetic units

`include "fpu_params.svh"

module fpu import fpu_pkg::*; (
  input  logic                   clk,
  input  logic                   arst,
  input  logic [`FPU_BYTE_W-1:0] databus_in,
  output logic [`FPU_BYTE_W-1:0] databus_out,
  input  logic [`FPU_ADDR_W-1:0] addr,
  input  logic                   cs,       // active low
  input  logic                   rd,       // active low
  input  logic                   wr,       // active low
  input  logic                   end_ack,
  output logic                   cmd_end,
  output logic                   busy
);

  fpu_operands_t operands;
  fpu_op_e       op;
  fpu_word_t     addsub_res;
  fpu_word_t     mul_res;
  mul_cmd_t      mul_cmd;
  logic          start;
  logic          idle;
  logic          capture;
  logic          capture_sel;
  logic          mul_last;
  logic          subtract;

  assign subtract = op == op_sub;  // straight from the opcode register

  fpu_reg_bank reg_bank_i (
    .clk, .arst, .cs, .rd, .wr, .addr,
    .databus_in, .databus_out,
    .idle, .capture, .capture_sel,
    .addsub_res, .mul_res,
    .operands, .op, .start
  );

  fpu_add_sub add_sub_i (
    .operands,
    .subtract,
    .result   (addsub_res)
  );

  fpu_mul_unit mul_unit_i (
    .clk, .arst,
    .operands,
    .mul_cmd,
    .mul_last,
    .result   (mul_res)
  );

  fpu_sequencer sequencer_i (
    .clk, .arst,
    .start, .op, .mul_last, .end_ack,
    .idle, .mul_cmd, .capture, .capture_sel,
    .busy, .cmd_end
  );

endmodule

/* verification/fpu_asserts.sv */
// fpu sequencer protocol checks
// busy to cmd_end hand-over, cmd_end hold until end_ack, multiply latency

module fpu_asserts import fpu_pkg::*; (
  input logic       clk,
  input logic       arst,
  input fpu_state_e state,
  input logic       busy,
  input logic       cmd_end,
  input logic       end_ack
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;  // summed into the testbench error count

  // cmd_end takes over from busy in the same cycle, never from idle
  flags_handover: assert property (
    @(posedge clk) disable iff (arst) $fell(busy) == $rose(cmd_end)
  ) else begin
    $error("busy fall and cmd_end rise not in the same cycle");
    fail_cnt++;
  end

  end_held: assert property (
    @(posedge clk) disable iff (arst) cmd_end && !end_ack |=> cmd_end
  ) else begin
    $error("cmd_end dropped without end_ack");
    fail_cnt++;
  end

  // done entered from norm, idle left 50 cycles earlier
  mul_latency: assert property (
    @(posedge clk) disable iff (arst)
    state == done_st && $past(state) == mul_norm_st
      |-> $past(state, 50) == mul_load_st && $past(state, 51) == idle_st
  ) else begin
    $error("multiply did not take 50 cycles from idle to done");
    fail_cnt++;
  end

endmodule

/* verification/fpu_tb.sv */
// fpu testbench
// directed tests over the byte bus: reset values, register map,
// add/sub/mul results against real arithmetic, opcode rewrite while busy

`include "fpu_params.svh"

module fpu_tb import fpu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_ops    = 20;  // 5 add, 4 sub, 9 mul, bad opcode, rewrite
  localparam int max_cycles = 100 * num_ops;
  localparam int add_lat    = 2;   // opcode write edge to cmd_end, in cycles
  localparam int mul_lat    = 51;

  logic                   clk = 1'b0;
  logic                   arst;
  logic                   cs;
  logic                   rd;
  logic                   wr;
  logic                   end_ack;
  logic [`FPU_ADDR_W-1:0] addr;
  logic [`FPU_BYTE_W-1:0] databus_in;
  logic [`FPU_BYTE_W-1:0] databus_out;
  logic                   cmd_end;
  logic                   busy;
  int                     cycle_cnt   = 0;
  int                     n_tests     = 0;
  int                     n_checks    = 0;
  int                     n_errors    = 0;
  int                     last_errors = 0;
  logic [31:0]            lfsr = 32'h4df9_3a01;

  fpu fpu_i (
    .clk, .arst, .databus_in, .databus_out, .addr,
    .cs, .rd, .wr, .end_ack, .cmd_end, .busy
  );

  bind fpu_sequencer fpu_asserts asserts_i (
    .clk(clk), .arst(arst), .state(state),
    .busy(busy), .cmd_end(cmd_end), .end_ack(end_ack)
  );

  always #20 clk = ~clk;  // 40 ns period

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > max_cycles) begin
      $display("timeout: run still going after %0d cycles", max_cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);  // one step per bit
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // exponent 2^-7..2^8, 8 fraction bits, so sums and products stay exact
  function automatic real rand_real();
    logic [31:0] r;
    r = take_bits(13);
    return $bitstoreal({r[12], 11'd1016 + {7'd0, r[11:8]}, r[7:0], 44'd0});
  endfunction

  // double to single by field copy, exact values only
  function automatic fpu_word_t to_single(real r);
    logic [63:0] d;
    fpu_word_t   w;
    d = $realtobits(r);
    w = '0;
    if (r != 0.0) begin
      w.sign = d[63];
      w.exp  = 8'(d[62:52] - 11'd896);  // rebias 1023 to 127
      w.frac = d[51:29];
    end
    return w;
  endfunction

  task automatic check_word(string what, fpu_word_t got, fpu_word_t want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("[FAIL] %0d ns: %s, got %h expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_byte(string what, logic [`FPU_BYTE_W-1:0] got,
                            logic [`FPU_BYTE_W-1:0] want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("[FAIL] %0d ns: %s, got %h expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_flag(string what, logic got, logic want);
    n_checks++;
    if (got !== want) begin
      n_errors++;
      $display("[FAIL] %0d ns: %s, got %b expected %b", $time, what, got, want);
    end
  endtask

  task automatic report_test(string name);
    n_tests++;
    if (n_errors == last_errors) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, n_errors - last_errors);
    last_errors = n_errors;
  endtask

  // bus tasks enter and leave just after a falling edge
  task automatic write_byte(logic [`FPU_ADDR_W-1:0] a, logic [`FPU_BYTE_W-1:0] d);
    addr       = a;
    databus_in = d;
    cs         = 1'b0;
    wr         = 1'b0;
    @(negedge clk);  // taken on the rising edge in between
    cs = 1'b1;
    wr = 1'b1;
  endtask

  task automatic read_byte(logic [`FPU_ADDR_W-1:0] a, output logic [`FPU_BYTE_W-1:0] d);
    addr = a;
    cs   = 1'b0;
    rd   = 1'b0;
    @(negedge clk);
    d  = databus_out;  // settled for half a cycle
    cs = 1'b1;
    rd = 1'b1;
  endtask

  task automatic write_word(logic [`FPU_ADDR_W-1:0] base, fpu_word_t w);
    for (int i = 0; i < 4; i++)
      write_byte(base + `FPU_ADDR_W'(i), w[i*`FPU_BYTE_W +: `FPU_BYTE_W]);
  endtask

  task automatic read_word(logic [`FPU_ADDR_W-1:0] base, output fpu_word_t w);
    logic [`FPU_BYTE_W-1:0] d;
    for (int i = 0; i < 4; i++) begin
      read_byte(base + `FPU_ADDR_W'(i), d);
      w[i*`FPU_BYTE_W +: `FPU_BYTE_W] = d;  // lsb first
    end
  endtask

  // falling edges until cmd_end, busy_held drops on any idle gap
  task automatic wait_done(output int cycles, output logic busy_held);
    cycles    = 0;
    busy_held = 1'b1;
    while (!cmd_end && cycles < 4 * mul_lat) begin
      @(negedge clk);
      cycles++;
      if (!cmd_end && !busy) busy_held = 1'b0;
    end
    if (!cmd_end) begin
      n_errors++;
      $display("cmd_end did not rise within %0d cycles of the opcode write", cycles);
    end
  endtask

  task automatic ack_done();
    end_ack = 1'b1;
    @(negedge clk);
    end_ack = 1'b0;
  endtask

  task automatic run_op(fpu_op_e op, output fpu_word_t res);
    int   cycles;
    logic busy_held;
    write_byte(`FPU_REG_OP, {4'd0, op});
    wait_done(cycles, busy_held);
    check_flag("busy while running", busy_held, 1'b1);
    check_flag($sformatf("cmd_end after %0d cycles", cycles),
               cycles == (op == op_mul ? mul_lat : add_lat), 1'b1);
    read_word(`FPU_REG_R0, res);
    ack_done();
    check_flag("cmd_end after ack", cmd_end, 1'b0);
  endtask

  task automatic arith_case(fpu_op_e op, real a, real b);
    fpu_word_t res;
    real       want;
    write_word(`FPU_REG_A0, to_single(a));
    write_word(`FPU_REG_B0, to_single(b));
    run_op(op, res);
    case (op)
      op_add:  want = a + b;
      op_sub:  want = a - b;
      default: want = a * b;
    endcase
    check_word($sformatf("%s %g, %g", op.name(), a, b), res, to_single(want));
  endtask

  task automatic test_reset();
    fpu_word_t              w;
    logic [`FPU_BYTE_W-1:0] d;
    check_flag("busy after reset", busy, 1'b0);
    check_flag("cmd_end after reset", cmd_end, 1'b0);
    read_word(`FPU_REG_A0, w);
    check_word("operand a after reset", w, '0);
    read_word(`FPU_REG_B0, w);
    check_word("operand b after reset", w, '0);
    read_byte(`FPU_REG_OP, d);
    check_byte("opcode after reset", d, '0);
    read_word(`FPU_REG_R0, w);
    check_word("result after reset", w, '0);
  endtask

  task automatic test_reg_map();
    fpu_word_t              w;
    logic [`FPU_BYTE_W-1:0] d;
    write_word(`FPU_REG_A0, 32'hc1a2_b3d4);
    write_word(`FPU_REG_B0, 32'h5e6f_7081);
    write_byte(`FPU_REG_OP, 8'h0f);  // not an opcode, sequencer stays idle
    read_word(`FPU_REG_A0, w);
    check_word("operand a readback", w, 32'hc1a2_b3d4);
    read_word(`FPU_REG_B0, w);
    check_word("operand b readback", w, 32'h5e6f_7081);
    read_byte(`FPU_REG_OP, d);
    check_byte("opcode readback", d, 8'h0f);
    for (int a = 13; a < 16; a++) begin
      read_byte(`FPU_ADDR_W'(a), d);
      check_byte($sformatf("unmapped address %0d", a), d, '0);
    end
    check_flag("busy after bad opcode", busy, 1'b0);
    check_flag("cmd_end after bad opcode", cmd_end, 1'b0);
  endtask

  task automatic test_add();
    arith_case(op_add, 1.5, 2.25);
    arith_case(op_add, -3.0, 1.25);
    arith_case(op_add, 5.5, -5.5);  // cancels to zero
    arith_case(op_add, -0.75, -10.0);
    arith_case(op_add, 100.0, -0.375);
  endtask

  task automatic test_sub();
    arith_case(op_sub, 7.0, 2.5);
    arith_case(op_sub, 2.5, 7.0);
    arith_case(op_sub, -1.5, -6.0);
    arith_case(op_sub, 0.625, -12.0);
  endtask

  task automatic test_mul();
    arith_case(op_mul, 1.5, 2.5);
    arith_case(op_mul, -3.0, 0.125);
    arith_case(op_mul, 12.0, -0.75);
    for (int i = 0; i < 6; i++)
      arith_case(op_mul, rand_real(), rand_real());
  endtask

  task automatic test_busy_rewrite();
    fpu_word_t res;
    int        cycles;
    logic      busy_held;
    write_word(`FPU_REG_A0, to_single(3.0));
    write_word(`FPU_REG_B0, to_single(-2.5));
    write_byte(`FPU_REG_OP, {4'd0, op_mul});
    repeat (5) @(negedge clk);
    check_flag("busy during multiply", busy, 1'b1);
    write_byte(`FPU_REG_OP, {4'd0, op_add});  // lands mid multiply
    wait_done(cycles, busy_held);
    check_flag("busy until cmd_end", busy_held, 1'b1);
    check_flag($sformatf("multiply kept running, %0d cycles", cycles),
               cycles == mul_lat - 6, 1'b1);
    read_word(`FPU_REG_R0, res);
    check_word("product after opcode rewrite", res, to_single(-7.5));
    ack_done();
    repeat (3) @(negedge clk);
    check_flag("busy after ack", busy, 1'b0);
    check_flag("cmd_end after ack", cmd_end, 1'b0);
  endtask

  initial begin
    arst       = 1'b1;
    cs         = 1'b1;
    rd         = 1'b1;
    wr         = 1'b1;
    end_ack    = 1'b0;
    addr       = '0;
    databus_in = '0;
    repeat (5) @(negedge clk);
    arst = 1'b0;
    test_reset();
    report_test("reset state");
    test_reg_map();
    report_test("register map");
    test_add();
    report_test("add");
    test_sub();
    report_test("sub");
    test_mul();
    report_test("mul");
    test_busy_rewrite();
    report_test("opcode while busy");
    n_errors += fpu_i.sequencer_i.asserts_i.fail_cnt;  // concurrent assertion hits
    $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* fpu.f */
+incdir+include
rtl/fpu_pkg.sv
rtl/fpu_reg_bank.sv
rtl/fpu_add_sub.sv
rtl/fpu_mul_unit.sv
rtl/fpu_sequencer.sv
rtl/fpu.sv
verification/fpu_asserts.sv
verification/fpu_tb.sv

/* Makefile */
# Verilator build and run of the fpu testbench

VERILATOR ?= verilator
TOP       ?= fpu_tb
FILELIST  ?= fpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -j 0
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG  ?= Testbench passed

SOURCES := $(shell grep '\.sv$$' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
